// ==== hw/cache_pkg.sv ====
// Shared widths and structs for the cache; fixed 32-bit words, 4-word lines, 30-bit word address
package cache_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int word_w      = 32;   // Processor data word
    localparam int line_w      = 128;  // Cache line and memory bus
    localparam int addr_w      = 30;   // Processor word address
    localparam int line_addr_w = 28;   // Word address minus word offset

    // Processor request, held until stall is low
    typedef struct packed {
        logic                read;
        logic                write;
        logic [addr_w-1:0]   addr;
        logic [word_w-1:0]   wdata;
    } proc_req_t;

    // Memory request, held until mem_ready
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [line_addr_w-1:0] addr;
        logic [line_w-1:0]      wdata;
    } mem_req_t;

    // Per-way report for the indexed set
    typedef struct packed {
        logic                   hit;
        logic                   valid;
        logic                   dirty;
        logic [line_addr_w-1:0] line_addr;  // Tag and index rebuilt
    } way_status_t;

    // Line picked for eviction
    typedef struct packed {
        logic                   dirty;
        logic [line_addr_w-1:0] line_addr;
        logic [line_w-1:0]      data;
    } victim_t;

endpackage

// ==== hw/cache_way.sv ====
// One cache way; set_bits of 1 to 4, fill and write hit never occur in the same cycle
`timescale 1ns/1ps

module cache_way #(
    parameter int set_bits = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  cache_pkg::proc_req_t         proc_req,
    input  logic                         fill_en,
    input  logic                         fill_dirty,
    input  logic [cache_pkg::line_w-1:0] fill_line,
    output cache_pkg::way_status_t       status,
    output logic [cache_pkg::word_w-1:0] word,
    output logic [cache_pkg::line_w-1:0] line
);
    import cache_pkg::*;

    localparam int sets  = 1 << set_bits;
    localparam int tag_w = line_addr_w - set_bits;

    logic [sets-1:0]     valid_q;
    logic [sets-1:0]     dirty_q;
    logic [tag_w-1:0]    tag_q  [sets];
    logic [line_w-1:0]   data_q [sets];

    logic [1:0]          offset;
    logic [set_bits-1:0] index;
    logic [tag_w-1:0]    tag;
    logic                hit;
    logic                write_hit;

    // --------------------
    // Lookup
    // --------------------
    assign offset    = proc_req.addr[1:0];
    assign index     = proc_req.addr[2 +: set_bits];
    assign tag       = proc_req.addr[addr_w-1 -: tag_w];
    assign hit       = valid_q[index] && (tag_q[index] == tag);
    assign write_hit = proc_req.write && hit;

    assign line = data_q[index];
    assign word = line[offset*word_w +: word_w];

    assign status = '{hit: hit,
                      valid: valid_q[index],
                      dirty: dirty_q[index],
                      line_addr: {tag_q[index], index}};

    // --------------------
    // State bits
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= fill_dirty;  // Set when a write missed
        end else if (write_hit) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // Tag and line storage
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[index]  <= tag;
            data_q[index] <= fill_line;
        end else if (write_hit) begin
            data_q[index][offset*word_w +: word_w] <= proc_req.wdata;  // Word merge
        end
    end

endmodule

// ==== hw/hit_select.sv ====
// Merges the two ways and keeps one LRU bit per set; read data is zero unless a read hits
`timescale 1ns/1ps

module hit_select #(
    parameter int set_bits = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  cache_pkg::proc_req_t         proc_req,
    input  cache_pkg::way_status_t       status0,
    input  cache_pkg::way_status_t       status1,
    input  logic [cache_pkg::word_w-1:0] word0,
    input  logic [cache_pkg::word_w-1:0] word1,
    input  logic [cache_pkg::line_w-1:0] line0,
    input  logic [cache_pkg::line_w-1:0] line1,
    output logic [cache_pkg::word_w-1:0] rdata,
    output logic                         stall,
    output logic                         miss,
    output logic                         victim_way,
    output cache_pkg::victim_t           victim
);
    import cache_pkg::*;

    localparam int sets = 1 << set_bits;

    logic [sets-1:0]     lru_q;  // Holds the least recently used way
    logic [set_bits-1:0] index;
    logic                active;
    logic                any_hit;
    way_status_t         vic_status;

    assign index   = proc_req.addr[2 +: set_bits];
    assign active  = proc_req.read || proc_req.write;
    assign any_hit = status0.hit || status1.hit;

    // --------------------
    // Processor reply
    // --------------------
    assign rdata = (proc_req.read && status0.hit) ? word0 :
                   (proc_req.read && status1.hit) ? word1 : '0;
    assign miss  = active && !any_hit;
    assign stall = miss;  // Only a miss holds the processor

    // --------------------
    // Victim choice
    // --------------------
    assign victim_way       = lru_q[index];
    assign vic_status       = victim_way ? status1 : status0;
    assign victim.dirty     = vic_status.valid && vic_status.dirty;
    assign victim.line_addr = vic_status.line_addr;
    assign victim.data      = victim_way ? line1 : line0;

    // Point at the way that did not hit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (active && any_hit) begin
            lru_q[index] <= status0.hit;
        end
    end

endmodule

// ==== hw/refill_ctrl.sv ====
// Miss handler; memory must answer each request with exactly one mem_ready pulse
`timescale 1ns/1ps

module refill_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  cache_pkg::proc_req_t         proc_req,
    input  logic                         miss,
    input  logic                         victim_way,
    input  cache_pkg::victim_t           victim,
    input  logic [cache_pkg::line_w-1:0] mem_rdata,
    input  logic                         mem_ready,
    output cache_pkg::mem_req_t          mem_req,
    output logic [1:0]                   fill_en,
    output logic                         fill_dirty,
    output logic [cache_pkg::line_w-1:0] fill_line
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        idle,
        write_back,
        fetch
    } refill_state_t;

    refill_state_t          state_q;
    logic                   fill_way_q;  // Victim way latched at miss start
    logic [line_addr_w-1:0] req_line;
    logic                   fill_now;

    assign req_line = proc_req.addr[addr_w-1:2];

    // --------------------
    // Memory request FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q       <= idle;
            fill_way_q    <= 1'b0;
            mem_req.read  <= 1'b0;
            mem_req.write <= 1'b0;
        end else begin
            case (state_q)
                idle: begin
                    if (miss) begin
                        fill_way_q <= victim_way;
                        if (victim.dirty) begin
                            // Old line goes out first
                            state_q       <= write_back;
                            mem_req.write <= 1'b1;
                            mem_req.addr  <= victim.line_addr;
                            mem_req.wdata <= victim.data;
                        end else begin
                            state_q      <= fetch;
                            mem_req.read <= 1'b1;
                            mem_req.addr <= req_line;
                        end
                    end
                end
                write_back: begin
                    if (mem_ready) begin
                        state_q       <= fetch;
                        mem_req.write <= 1'b0;
                        mem_req.read  <= 1'b1;
                        mem_req.addr  <= req_line;
                    end
                end
                fetch: begin
                    if (mem_ready) begin
                        state_q      <= idle;  // Next cycle hits
                        mem_req.read <= 1'b0;
                    end
                end
                default: begin
                    state_q <= idle;
                end
            endcase
        end
    end

    // --------------------
    // Line fill
    // --------------------
    assign fill_now   = (state_q == fetch) && mem_ready;
    assign fill_en    = fill_now ? (fill_way_q ? 2'b10 : 2'b01) : 2'b00;
    assign fill_dirty = proc_req.write;  // Write miss leaves the line dirty
    assign fill_line  = mem_rdata;       // Valid only in the ready cycle

endmodule

// ==== hw/l2_cache.sv ====
// Two-way write-back data cache top; set_bits from 1 to 4, processor holds requests while stalled
`timescale 1ns/1ps

module l2_cache #(
    parameter int set_bits = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  cache_pkg::proc_req_t         proc_req,
    output logic [cache_pkg::word_w-1:0] rdata,
    output logic                         stall,
    output cache_pkg::mem_req_t          mem_req,
    input  logic [cache_pkg::line_w-1:0] mem_rdata,
    input  logic                         mem_ready
);
    import cache_pkg::*;

    way_status_t       status0;
    way_status_t       status1;
    logic [word_w-1:0] word0;
    logic [word_w-1:0] word1;
    logic [line_w-1:0] line0;
    logic [line_w-1:0] line1;
    logic              miss;
    logic              victim_way;
    victim_t           victim;
    logic [1:0]        fill_en;     // One bit per way
    logic              fill_dirty;
    logic [line_w-1:0] fill_line;

    // --------------------
    // Ways
    // --------------------
    cache_way #(.set_bits(set_bits)) u_way0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_req   (proc_req),
        .fill_en    (fill_en[0]),
        .fill_dirty (fill_dirty),
        .fill_line  (fill_line),
        .status     (status0),
        .word       (word0),
        .line       (line0)
    );

    cache_way #(.set_bits(set_bits)) u_way1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_req   (proc_req),
        .fill_en    (fill_en[1]),
        .fill_dirty (fill_dirty),
        .fill_line  (fill_line),
        .status     (status1),
        .word       (word1),
        .line       (line1)
    );

    // --------------------
    // Hit merge and refill
    // --------------------
    hit_select #(.set_bits(set_bits)) u_hit_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_req   (proc_req),
        .status0    (status0),
        .status1    (status1),
        .word0      (word0),
        .word1      (word1),
        .line0      (line0),
        .line1      (line1),
        .rdata      (rdata),
        .stall      (stall),
        .miss       (miss),
        .victim_way (victim_way),
        .victim     (victim)
    );

    refill_ctrl u_refill_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .proc_req   (proc_req),
        .miss       (miss),
        .victim_way (victim_way),
        .victim     (victim),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .mem_req    (mem_req),
        .fill_en    (fill_en),
        .fill_dirty (fill_dirty),
        .fill_line  (fill_line)
    );

endmodule

// ==== tests/tb_l2_cache.sv ====
// Cache testbench; runs from the project root, reads tests/cache_tests.hex, set_bits fixed at 2
`timescale 1ns/1ps

module tb_l2_cache;
    import cache_pkg::*;

    localparam int clk_period  = 40;
    localparam int max_tests   = 64;
    localparam int fields      = 5;    // Words per access in the data file
    localparam int stall_limit = 100;  // Cycles one access may stall

    logic              clk;
    logic              rst_n;
    proc_req_t         proc_req;
    logic [word_w-1:0] rdata;
    logic              stall;
    mem_req_t          mem_req;
    logic [line_w-1:0] mem_rdata;
    logic              mem_ready;

    logic [31:0] vectors [max_tests*fields];
    logic [31:0] mem_words [logic [addr_w-1:0]];  // Only words written back
    logic [31:0] lfsr_state  = 32'h7346_cb72;
    int          n_tests     = 0;
    int          fetch_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    l2_cache #(.set_bits(2)) u_l2_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .proc_req  (proc_req),
        .rdata     (rdata),
        .stall     (stall),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    initial clk = 1'b0;
    always #(clk_period/2) clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    // Galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic draw_bits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [addr_w-1:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return {2'b00, addr} ^ 32'ha5a5_0000;  // Untouched word
    endfunction

    function automatic logic [line_w-1:0] load_line(input logic [line_addr_w-1:0] line_addr);
        logic [line_w-1:0] data;
        int                i;
        for (i = 0; i < 4; i++) begin
            data[i*word_w +: word_w] = mem_word({line_addr, 2'(i)});
        end
        return data;
    endfunction

    task automatic store_line(input logic [line_addr_w-1:0] line_addr,
                              input logic [line_w-1:0]      data);
        int i;
        for (i = 0; i < 4; i++) begin
            mem_words[{line_addr, 2'(i)}] = data[i*word_w +: word_w];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // --------------------
    // Memory model
    // --------------------
    // One mem_ready pulse per request after 0 to 3 idle cycles
    initial begin : memory_model
        int delay;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            mem_ready = 1'b0;
            if (rst_n && (mem_req.read || mem_req.write)) begin
                draw_bits(2, delay);
                repeat (delay) @(negedge clk);
                if (mem_req.write) begin
                    store_line(mem_req.addr, mem_req.wdata);
                end else begin
                    mem_rdata   = load_line(mem_req.addr);
                    fetch_count = fetch_count + 1;
                end
                mem_ready = 1'b1;
            end
        end
    end

    // --------------------
    // Test steps
    // --------------------
    task automatic check_idle_after_reset();
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        proc_req = '0;
        #(clk_period/4);
        check_value("stall", 32'(stall), 32'd0);
        check_value("mem_req.read", 32'(mem_req.read), 32'd0);
        check_value("mem_req.write", 32'(mem_req.write), 32'd0);
        $display("test 0 reset state: %s", (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    task automatic run_access(input int idx);
        int                base;
        int                waited;
        int                errors_before;
        int                fetches_before;
        logic              is_write;
        logic [addr_w-1:0] addr;
        logic [31:0]       wdata;
        logic [31:0]       exp_rdata;
        logic [31:0]       exp_fetches;
        base          = idx * fields;
        is_write      = vectors[base][0];
        addr          = vectors[base+1][addr_w-1:0];
        wdata         = vectors[base+2];
        exp_rdata     = vectors[base+3];
        exp_fetches   = vectors[base+4];
        errors_before = error_count;
        waited        = 0;

        @(negedge clk);
        fetches_before = fetch_count;
        proc_req.read  = !is_write;
        proc_req.write = is_write;
        proc_req.addr  = addr;
        proc_req.wdata = wdata;
        #(clk_period/4);  // Mid low phase
        while (stall && waited < stall_limit) begin
            @(negedge clk);
            #(clk_period/4);
            waited++;
        end

        if (stall) begin
            error_count++;
            $display("access %0d to %h still stalled after %0d cycles", idx + 1, addr,
                     stall_limit);
        end else begin
            if (!is_write) begin
                check_value("rdata", rdata, exp_rdata);
            end
            if (exp_fetches == 0) begin
                check_value("stall cycles", 32'(waited), 32'd0);  // Hits answer at once
            end
            check_value("memory fetches", 32'(fetch_count - fetches_before), exp_fetches);
        end
        @(posedge clk);  // Request taken here
        $display("test %0d %s %h: %s", idx + 1, is_write ? "write" : "read", addr,
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    // --------------------
    // Sequence
    // --------------------
    initial begin : test_sequence
        int i;
        rst_n    = 1'b0;
        proc_req = '0;
        for (i = 0; i < max_tests*fields; i++) begin
            vectors[i] = '1;  // End marker where the file stops
        end
        $readmemh("tests/cache_tests.hex", vectors);
        while (n_tests < max_tests && vectors[n_tests*fields] != 32'hffff_ffff) begin
            n_tests++;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_idle_after_reset();
        if (n_tests == 0) begin
            error_count++;
            $display("no accesses were loaded from tests/cache_tests.hex");
        end
        for (i = 0; i < n_tests; i++) begin
            run_access(i);
        end
        @(negedge clk);
        proc_req = '0;

        $display("%0d tests, %0d checks, %0d errors", n_tests + 1, check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Limit scales with the number of accesses
    initial begin : watchdog
        wait (n_tests > 0);
        #((n_tests + 1) * 200 * clk_period);
        $display("timeout: the accesses did not finish within %0d cycles",
                 (n_tests + 1) * 200);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
hw/cache_pkg.sv
hw/cache_way.sv
hw/hit_select.sv
hw/refill_ctrl.sv
hw/l2_cache.sv
tests/tb_l2_cache.sv

// ==== Makefile ====
TOP = tb_l2_cache

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// ==== tests/cache_tests.hex ====
// Columns: op (0 read, 1 write), word address, write data, expected read data, expected fetches
// Fill pattern is word address xor a5a50000; set index is address bits 3:2, four sets of two ways
0 00000001 00000000 a5a50001 1  // Set 0 cold miss
0 00000003 00000000 a5a50003 0
1 00000002 11112222 00000000 0  // Write hit, line now dirty
0 00000002 00000000 11112222 0
0 00000004 00000000 a5a50004 1  // Set 1 lines A B A C
0 00000015 00000000 a5a50015 1
0 00000006 00000000 a5a50006 0
0 00000027 00000000 a5a50027 1
0 00000005 00000000 a5a50005 0
0 00000014 00000000 a5a50014 1
1 00000009 cafe0009 00000000 1  // Set 2 write miss
0 00000009 00000000 cafe0009 0
0 00000008 00000000 a5a50008 0
0 00000018 00000000 a5a50018 1
0 0000002a 00000000 a5a5002a 1  // Dirty victim goes out
0 0000003b 00000000 a5a5003b 1
0 00000009 00000000 cafe0009 1
0 0000000a 00000000 a5a5000a 0
1 0000000d 0d0d0d0d 00000000 1  // Set 3 two dirty lines
1 0000001e 1e1e1e1e 00000000 1
0 0000000c 00000000 a5a5000c 0
0 0000002f 00000000 a5a5002f 1
0 0000003c 00000000 a5a5003c 1
0 0000001e 00000000 1e1e1e1e 1
0 0000001f 00000000 a5a5001f 0
0 0000000d 00000000 0d0d0d0d 1
0 0000000e 00000000 a5a5000e 0
0 00000041 00000000 a5a50041 1  // Set 0 evicts the dirty write hit
0 00000082 00000000 a5a50082 1
0 00000002 00000000 11112222 1
0 00000000 00000000 a5a50000 0
0 00000003 00000000 a5a50003 0
1 3ffffff5 5555aaaa 00000000 1  // Top tag bits
0 3ffffff5 00000000 5555aaaa 0
0 3ffffff4 00000000 9a5afff4 0
0 00000024 00000000 a5a50024 1
0 00000014 00000000 a5a50014 1
0 3ffffff7 00000000 9a5afff7 1
0 3ffffff5 00000000 5555aaaa 0
1 3ffffff6 66667777 00000000 0  // Write hit in way 1
0 3ffffff6 00000000 66667777 0
0 00000015 00000000 a5a50015 0
